/* filelist.f */
src/ads_pkg.sv
src/axil_regs.sv
src/ads_ctrl.sv
src/spi_byte_master.sv
src/ads124x_top.sv
sim/tb_clock.sv
sim/adc_model.sv
sim/ads_checker.sv
sim/tb_ads124x.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ads124x -f filelist.f -o tb_ads124x &&
out=$(./obj_dir/tb_ads124x || true) &&
echo "$out" &&
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1

/* sim/adc_model.sv */
`default_nettype none

module adc_model (
    input  logic        aclk,
    input  logic        sclk,
    input  logic        cs_n,
    input  logic        mosi,
    input  logic        drdy_req,
    input  logic [31:0] reply,
    output logic        miso,
    output logic        drdy_n,
    output logic [31:0] mosi_log,
    output logic [3:0]  log_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        sclk_d;
    logic        cs_d;
    logic [31:0] shift;
    logic [7:0]  rx;
    logic [2:0]  bit_cnt;

    initial begin
        miso      = 1'b0;
        drdy_n    = 1'b1;
        sclk_d    = 1'b0;
        cs_d      = 1'b1;
        shift     = 32'd0;
        rx        = 8'd0;
        bit_cnt   = 3'd0;
        mosi_log  = 32'd0;
        log_count = 4'd0;
    end

    // Mode 1 device, next bit goes out on each rising SCLK edge
    always @(posedge aclk) begin
        sclk_d <= sclk;
        cs_d   <= cs_n;
        drdy_n <= !drdy_req;
        if (cs_d && !cs_n) begin
            shift     <= reply;
            mosi_log  <= 32'd0;
            log_count <= 4'd0;
            bit_cnt   <= 3'd0;
        end else if (!cs_n && sclk && !sclk_d) begin
            miso    <= shift[31];
            shift   <= {shift[30:0], 1'b0};
            rx      <= {rx[6:0], mosi};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                mosi_log  <= {mosi_log[23:0], rx[6:0], mosi};
                log_count <= log_count + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/ads_checker.sv */
`default_nettype none

module ads_checker (
    input logic        aclk,
    input logic        rst,
    input logic        s_axi_bvalid,
    input logic        s_axi_bready,
    input logic        s_axi_rvalid,
    input logic        s_axi_rready,
    input logic [31:0] s_axi_rdata,
    input logic        m_axis_tvalid,
    input logic        m_axis_tready,
    input logic [31:0] m_axis_tdata,
    input logic        sclk,
    input logic        cs_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Handshake stability
    // ==============================

    bvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed before rready");

    tvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
        else $error("tvalid or tdata changed before tready");

    // ==============================
    // Pins and reset
    // ==============================

    sclk_idle: assert property (@(posedge aclk) disable iff (rst) cs_n |-> !sclk)
        else $error("sclk active while cs_n high");

    tvalid_reset: assert property (@(posedge aclk) rst |=> !m_axis_tvalid)
        else $error("tvalid high after reset");

endmodule

bind ads124x_top ads_checker chk_i (
    .aclk          (aclk         ),
    .rst           (rst          ),
    .s_axi_bvalid  (s_axi_bvalid ),
    .s_axi_bready  (s_axi_bready ),
    .s_axi_rvalid  (s_axi_rvalid ),
    .s_axi_rready  (s_axi_rready ),
    .s_axi_rdata   (s_axi_rdata  ),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata ),
    .sclk          (sclk         ),
    .cs_n          (cs_n         )
);

`default_nettype wire

/* sim/tb_ads124x.sv */
`default_nettype none

module tb_ads124x;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {K_RD, K_WR, K_PINS, K_SPI, K_SAMPLE, K_OVF} kind_e;

    // The addr field carries nbytes for K_SPI
    // The model field is the ADC reply word
    typedef struct packed {
        kind_e              kind;
        logic [7:0]         addr;
        logic [31:0]        data;
        logic [31:0]        model;
        logic [31:0]        exp;
        ads_pkg::axi_resp_e resp;
    } step_t;

    localparam int  NSTEPS      = 16;
    localparam time WATCHDOG_NS = (NSTEPS * 200 + 100) * 40;

    logic aclk;
    logic rst;
    logic [31:0] awaddr, wdata, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;
    ads_pkg::axi_resp_e bresp, rresp;
    logic [31:0] rdata;
    logic [31:0] tdata;
    logic tvalid, tready;
    logic sclk, cs_n, mosi, miso, ad_reset_n, ad_start, drdy_n;
    logic drdy_req;
    logic [31:0] reply;
    logic [31:0] mosi_log;
    logic [3:0] log_count;

    step_t steps [NSTEPS];
    string names [NSTEPS];
    int mismatches;
    int failures;

    tb_clock clk_i (.clk(aclk));

    ads124x_top dut_i (
        .aclk(aclk), .rst(rst),
        .s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
        .s_axi_wdata(wdata), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
        .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
        .s_axi_araddr(araddr), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
        .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rvalid(rvalid),
        .s_axi_rready(rready),
        .m_axis_tdata(tdata), .m_axis_tvalid(tvalid), .m_axis_tready(tready),
        .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .ad_reset_n(ad_reset_n), .ad_start(ad_start), .drdy_n(drdy_n)
    );

    adc_model model_i (
        .aclk(aclk), .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .drdy_req(drdy_req),
        .reply(reply), .miso(miso), .drdy_n(drdy_n), .mosi_log(mosi_log),
        .log_count(log_count)
    );

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_resp(input string name, input ads_pkg::axi_resp_e exp,
                              input ads_pkg::axi_resp_e act);
        if (act !== exp) begin
            $display("mismatch %s resp: expected %s, actual %s", name, exp.name(), act.name());
            mismatches++;
        end
    endtask

    task automatic check_sample(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s sample: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bytes(input string name, input logic [31:0] exp, input logic [3:0] cnt);
        if (mosi_log !== exp || log_count !== cnt) begin
            $display("mismatch %s mosi: expected %0d bytes %h, actual %0d bytes %h",
                     name, cnt, exp, log_count, mosi_log);
            mismatches++;
        end
    endtask

    function automatic logic [31:0] sign_extend(input logic [23:0] w);
        return 32'($signed(w));
    endfunction

    // ==============================
    // Bus and pin tasks
    // ==============================

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output ads_pkg::axi_resp_e resp);
        @(posedge aclk);
        awaddr  <= {24'd0, addr};
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge aclk); while (!awready);
        if (!wready) begin
            $display("write to %h: wready did not pulse with awready", addr);
            failures++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge aclk); while (!bvalid);
        resp = bresp;
        // Late bready keeps the response pending for one cycle
        bready <= 1'b1;
        @(posedge aclk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output ads_pkg::axi_resp_e resp);
        @(posedge aclk);
        araddr  <= {24'd0, addr};
        arvalid <= 1'b1;
        do @(posedge aclk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge aclk); while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b1;
        @(posedge aclk);
        rready <= 1'b0;
    endtask

    task automatic pulse_drdy(input logic [31:0] word);
        @(posedge aclk);
        reply    <= {word[23:0], 8'h00};
        drdy_req <= 1'b1;
        repeat (4) @(posedge aclk);
        drdy_req <= 1'b0;
    endtask

    task automatic wait_tvalid();
        do @(posedge aclk); while (!tvalid);
    endtask

    task automatic run_step(input int i);
        step_t s;
        logic [31:0] rd;
        ads_pkg::axi_resp_e resp;
        int polls;
        s = steps[i];
        case (s.kind)
            K_RD: begin
                axi_read(s.addr, rd, resp);
                check_word(names[i], s.exp, rd);
                check_resp(names[i], s.resp, resp);
            end
            K_WR: begin
                axi_write(s.addr, s.data, resp);
                check_resp(names[i], s.resp, resp);
            end
            K_PINS: begin
                @(posedge aclk);
                check_word(names[i], s.exp, {30'd0, ad_reset_n, ad_start});
            end
            K_SPI: begin
                axi_write(ads_pkg::REG_SPICTRL, {30'd0, s.addr[1:0]}, resp);
                reply <= s.model;
                axi_write(ads_pkg::REG_SPISEND, s.data, resp);
                polls = 0;
                do begin
                    axi_read(ads_pkg::REG_STAT, rd, resp);
                    polls++;
                end while (rd[2] && polls < 100);
                if (rd[2]) begin
                    $display("%s: manual SPI transfer never finished", names[i]);
                    failures++;
                end
                axi_read(ads_pkg::REG_SPIRECV, rd, resp);
                check_word(names[i], s.exp, rd);
                check_bytes(names[i], s.data >> (8 * (3 - s.addr[1:0])),
                            4'(s.addr[1:0]) + 4'd1);
            end
            K_SAMPLE: begin
                tready <= 1'b1;
                pulse_drdy(s.model);
                wait_tvalid();
                check_sample(names[i], sign_extend(s.model[23:0]), tdata);
            end
            K_OVF: begin
                tready <= 1'b0;
                pulse_drdy(s.model);
                wait_tvalid();
                pulse_drdy(~s.model);
                repeat (8) @(posedge aclk);
                axi_read(ads_pkg::REG_STAT, rd, resp);
                check_word(names[i], 32'h0000_0002, rd);
                if (!tvalid) begin
                    $display("%s: held sample was lost", names[i]);
                    failures++;
                end
                check_sample(names[i], sign_extend(s.model[23:0]), tdata);
            end
            default: ;
        endcase
    endtask

    // ==============================
    // Stimulus table and run
    // ==============================

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the test did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(59));
        rst = 1'b1;
        awaddr = '0;
        wdata = '0;
        araddr = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        tready = 1'b0;
        drdy_req = 1'b0;
        reply = '0;
        mismatches = 0;
        failures = 0;

        steps[0]  = '{K_RD, 8'h00, 32'h0, 32'h0, 32'h2019_1226, ads_pkg::OKAY};
        steps[1]  = '{K_RD, 8'h18, 32'h0, 32'h0, 32'h0, ads_pkg::SLVERR};
        steps[2]  = '{K_WR, 8'h04, 32'h11, 32'h0, 32'h0, ads_pkg::OKAY};
        steps[3]  = '{K_RD, 8'h04, 32'h0, 32'h0, 32'h11, ads_pkg::OKAY};
        steps[4]  = '{K_PINS, 8'h0, 32'h0, 32'h0, 32'h1, ads_pkg::OKAY};
        steps[5]  = '{K_WR, 8'h04, 32'h0, 32'h0, 32'h0, ads_pkg::OKAY};
        steps[6]  = '{K_PINS, 8'h0, 32'h0, 32'h0, 32'h2, ads_pkg::OKAY};
        steps[7]  = '{K_SPI, 8'h2, 32'h1234_5600, 32'hA5C3_3C00, 32'h00A5_C33C, ads_pkg::OKAY};
        steps[8]  = '{K_WR, 8'h04, 32'h100, 32'h0, 32'h0, ads_pkg::OKAY};
        for (int i = 9; i < 13; i++) begin
            steps[i] = '{K_SAMPLE, 8'h0, 32'h0, 32'h0, 32'h0, ads_pkg::OKAY};
        end
        steps[13] = '{K_OVF, 8'h0, 32'h0, 32'h0, 32'h0, ads_pkg::OKAY};
        steps[14] = '{K_WR, 8'h08, 32'h2, 32'h0, 32'h0, ads_pkg::OKAY};
        steps[15] = '{K_RD, 8'h08, 32'h0, 32'h0, 32'h0, ads_pkg::OKAY};
        names = '{"version", "unmapped", "ctrl_wr", "ctrl_rd", "pins_on", "ctrl_clr",
                  "pins_off", "manual_spi", "cont_mode", "sample_0", "sample_1",
                  "sample_2", "sample_3", "overflow", "ovf_clear", "stat_clear"};

        // Random 24-bit conversion words, odd steps negative
        for (int i = 9; i < 14; i++) begin
            steps[i].model = $urandom & 32'h007F_FFFF;
            if (i[0]) begin
                steps[i].model[23] = 1'b1;
            end
        end

        repeat (4) @(posedge aclk);
        rst <= 1'b0;

        for (int i = 0; i < NSTEPS; i++) begin
            run_step(i);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

endmodule

`default_nettype wire

/* src/ads124x_top.sv */
`default_nettype none

module ads124x_top (
    input  logic                  aclk,
    input  logic                  rst,
    // AXI4-Lite slave
    input  logic [31:0]           s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  logic [31:0]           s_axi_wdata,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output ads_pkg::axi_resp_e    s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  logic [31:0]           s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [31:0]           s_axi_rdata,
    output ads_pkg::axi_resp_e    s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    // Sample stream
    output logic [31:0]           m_axis_tdata,
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready,
    // ADS124x SPI
    output logic                  sclk,
    output logic                  cs_n,
    output logic                  mosi,
    input  logic                  miso,
    // ADS124x GPIO
    output logic                  ad_reset_n,
    output logic                  ad_start,
    input  logic                  drdy_n
);

    ads_pkg::ctrl_reg_t ctrl;
    ads_pkg::spi_cmd_t  spi_cmd;
    ads_pkg::stat_t     stat;
    logic               spi_go;
    logic               clear_ovf;
    logic [31:0]        spi_recv;

    logic               byte_start;
    logic [7:0]         tx_byte;
    logic [7:0]         rx_byte;
    logic               byte_done;

    // ==============================
    // Register slave
    // ==============================

    axil_regs i_regs (
        .aclk          (aclk         ),
        .rst           (rst          ),
        .s_axi_awaddr  (s_axi_awaddr ),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata  ),
        .s_axi_wvalid  (s_axi_wvalid ),
        .s_axi_wready  (s_axi_wready ),
        .s_axi_bresp   (s_axi_bresp  ),
        .s_axi_bvalid  (s_axi_bvalid ),
        .s_axi_bready  (s_axi_bready ),
        .s_axi_araddr  (s_axi_araddr ),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata  ),
        .s_axi_rresp   (s_axi_rresp  ),
        .s_axi_rvalid  (s_axi_rvalid ),
        .s_axi_rready  (s_axi_rready ),
        .stat          (stat         ),
        .spi_recv      (spi_recv     ),
        .ctrl          (ctrl         ),
        .spi_cmd       (spi_cmd      ),
        .spi_go        (spi_go       ),
        .clear_ovf     (clear_ovf    )
    );

    // ==============================
    // Sequencer and SPI engine
    // ==============================

    ads_ctrl i_ctrl (
        .aclk          (aclk         ),
        .rst           (rst          ),
        .ctrl          (ctrl         ),
        .spi_cmd       (spi_cmd      ),
        .spi_go        (spi_go       ),
        .clear_ovf     (clear_ovf    ),
        .stat          (stat         ),
        .spi_recv      (spi_recv     ),
        .byte_start    (byte_start   ),
        .tx_byte       (tx_byte      ),
        .rx_byte       (rx_byte      ),
        .byte_done     (byte_done    ),
        .cs_n          (cs_n         ),
        .ad_reset_n    (ad_reset_n   ),
        .ad_start      (ad_start     ),
        .drdy_n        (drdy_n       ),
        .m_axis_tdata  (m_axis_tdata ),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

    spi_byte_master i_spi (
        .aclk          (aclk         ),
        .rst           (rst          ),
        .byte_start    (byte_start   ),
        .tx_byte       (tx_byte      ),
        .miso          (miso         ),
        .sclk          (sclk         ),
        .mosi          (mosi         ),
        .rx_byte       (rx_byte      ),
        .byte_done     (byte_done    )
    );

endmodule

`default_nettype wire

/* src/ads_ctrl.sv */
`default_nettype none

module ads_ctrl (
    input  logic                  aclk,
    input  logic                  rst,
    // Register side
    input  ads_pkg::ctrl_reg_t    ctrl,
    input  ads_pkg::spi_cmd_t     spi_cmd,
    input  logic                  spi_go,
    input  logic                  clear_ovf,
    output ads_pkg::stat_t        stat,
    output logic [31:0]           spi_recv,
    // SPI engine
    output logic                  byte_start,
    output logic [7:0]            tx_byte,
    input  logic [7:0]            rx_byte,
    input  logic                  byte_done,
    // ADC pins
    output logic                  cs_n,
    output logic                  ad_reset_n,
    output logic                  ad_start,
    input  logic                  drdy_n,
    // Sample stream
    output logic [31:0]           m_axis_tdata,
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready
);

    ads_pkg::seq_state_e state;

    logic [2:0]  drdy_sync;
    logic        drdy_fall;
    logic        idle;
    logic        man_go;
    logic        cont_go;
    logic        missed;
    logic        overflow;
    logic        cont;
    logic [1:0]  byte_cnt;
    logic [31:0] tx_shift;
    logic [31:0] rx_word;

    // Two flops against metastability, third one for the edge
    assign drdy_fall = drdy_sync[2] && !drdy_sync[1];

    assign idle = (state == ads_pkg::S_IDLE);

    // A sample may start while the held word leaves in the same cycle
    assign man_go  = idle && spi_go;
    assign cont_go = idle && !spi_go && ctrl.op_mode && drdy_fall &&
                     (!m_axis_tvalid || m_axis_tready);
    assign missed  = ctrl.op_mode && drdy_fall && !cont_go;

    assign stat = '{busy: !idle, overflow: overflow, drdy: !drdy_sync[1]};

    // ==============================
    // Sequencer
    // ==============================

    always_ff @(posedge aclk) begin
        byte_start <= 1'b0;
        if (rst) begin
            state         <= ads_pkg::S_IDLE;
            drdy_sync     <= 3'b111;
            cs_n          <= 1'b1;
            m_axis_tvalid <= 1'b0;
            overflow      <= 1'b0;
            ad_reset_n    <= 1'b0;
            ad_start      <= 1'b0;
        end else begin
            drdy_sync  <= {drdy_sync[1:0], drdy_n};
            ad_reset_n <= !ctrl.ad_reset;
            ad_start   <= ctrl.ad_start;

            if (missed) begin
                overflow <= 1'b1;
            end else if (clear_ovf) begin
                overflow <= 1'b0;
            end

            if (m_axis_tvalid && m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end

            case (state)
                ads_pkg::S_IDLE: begin
                    if (man_go || cont_go) begin
                        cs_n  <= 1'b0;
                        state <= ads_pkg::S_BYTE;
                    end
                end
                ads_pkg::S_BYTE: begin
                    byte_start <= 1'b1;
                    state      <= ads_pkg::S_WAIT;
                end
                ads_pkg::S_WAIT: begin
                    if (byte_done) begin
                        state <= (byte_cnt == 2'd0) ? ads_pkg::S_DONE : ads_pkg::S_BYTE;
                    end
                end
                ads_pkg::S_DONE: begin
                    cs_n  <= 1'b1;
                    state <= ads_pkg::S_IDLE;
                    if (cont) begin
                        m_axis_tvalid <= 1'b1;
                    end
                end
                default: state <= ads_pkg::S_IDLE;
            endcase
        end
    end

    // ==============================
    // Byte shifting and results
    // ==============================

    always_ff @(posedge aclk) begin
        case (state)
            ads_pkg::S_IDLE: begin
                if (man_go) begin
                    tx_shift <= spi_cmd.send;
                    byte_cnt <= spi_cmd.nbytes;
                    cont     <= 1'b0;
                    rx_word  <= 32'd0;
                end else if (cont_go) begin
                    // RDATA style read, clock out 0xFF filler
                    tx_shift <= 32'hFFFF_FFFF;
                    byte_cnt <= 2'(ads_pkg::SAMPLE_BYTES - 1);
                    cont     <= 1'b1;
                    rx_word  <= 32'd0;
                end
            end
            ads_pkg::S_BYTE: begin
                tx_byte  <= tx_shift[31:24];
                tx_shift <= {tx_shift[23:0], 8'h00};
            end
            ads_pkg::S_WAIT: begin
                if (byte_done) begin
                    rx_word  <= {rx_word[23:0], rx_byte};
                    byte_cnt <= byte_cnt - 2'd1;
                end
            end
            ads_pkg::S_DONE: begin
                if (cont) begin
                    m_axis_tdata <= {{8{rx_word[23]}}, rx_word[23:0]};
                end else begin
                    spi_recv <= rx_word;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/ads_pkg.sv */
`default_nettype none

package ads_pkg;

    // ==============================
    // Constants
    // ==============================

    localparam logic [31:0] VERSION_ID = 32'h2019_1226;

    // aclk cycles per SCLK half period, so a byte takes 64 cycles
    localparam int SCLK_HALF    = 4;
    localparam int SAMPLE_BYTES = 3;

    localparam int                    SCLK_DIV_W    = $clog2(SCLK_HALF);
    localparam logic [SCLK_DIV_W-1:0] SCLK_DIV_LAST = SCLK_DIV_W'(SCLK_HALF - 1);

    // CTRL bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_RESET_BIT = 4;
    localparam int CTRL_MODE_BIT  = 8;

    // Writing this STAT bit clears the overflow flag
    localparam int STAT_OVF_BIT = 1;

    // ==============================
    // Register map and bus types
    // ==============================

    typedef enum logic [7:0] {
        REG_VERSION = 8'h00,
        REG_CTRL    = 8'h04,
        REG_STAT    = 8'h08,
        REG_SPICTRL = 8'h0C,
        REG_SPISEND = 8'h10,
        REG_SPIRECV = 8'h14
    } reg_addr_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic op_mode;   // 1 selects continuous reads
        logic ad_reset;
        logic ad_start;
    } ctrl_reg_t;

    typedef struct packed {
        logic [31:0] send;
        logic [1:0]  nbytes;  // byte count minus one
    } spi_cmd_t;

    // Packed so that drdy is STAT bit 0 and overflow bit 1
    typedef struct packed {
        logic busy;
        logic overflow;
        logic drdy;
    } stat_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BYTE,
        S_WAIT,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* src/axil_regs.sv */
`default_nettype none

module axil_regs (
    input  logic                  aclk,
    input  logic                  rst,
    // AXI4-Lite slave
    input  logic [31:0]           s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  logic [31:0]           s_axi_wdata,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output ads_pkg::axi_resp_e    s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  logic [31:0]           s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [31:0]           s_axi_rdata,
    output ads_pkg::axi_resp_e    s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    // Sequencer side
    input  ads_pkg::stat_t        stat,
    input  logic [31:0]           spi_recv,
    output ads_pkg::ctrl_reg_t    ctrl,
    output ads_pkg::spi_cmd_t     spi_cmd,
    output logic                  spi_go,
    output logic                  clear_ovf
);

    logic        bus_busy;
    logic        wr_take;
    logic        rd_take;
    logic        wr_hit;
    logic        rd_hit;
    logic [31:0] rd_word;

    // Offset must be in the map and the upper address bits zero
    function automatic logic addr_mapped(input logic [31:0] addr);
        logic hit;
        case (addr[7:0])
            ads_pkg::REG_VERSION,
            ads_pkg::REG_CTRL,
            ads_pkg::REG_STAT,
            ads_pkg::REG_SPICTRL,
            ads_pkg::REG_SPISEND,
            ads_pkg::REG_SPIRECV: hit = 1'b1;
            default:              hit = 1'b0;
        endcase
        return hit && (addr[31:8] == 24'd0);
    endfunction

    // ==============================
    // Handshake
    // ==============================

    // One request at a time, writes win a tie
    assign bus_busy = s_axi_awready || s_axi_bvalid || s_axi_arready || s_axi_rvalid;
    assign wr_take  = !bus_busy && s_axi_awvalid && s_axi_wvalid;
    assign rd_take  = !bus_busy && s_axi_arvalid && !wr_take;

    assign s_axi_wready = s_axi_awready;

    assign wr_hit = addr_mapped(s_axi_awaddr);
    assign rd_hit = addr_mapped(s_axi_araddr);

    always_ff @(posedge aclk) begin
        if (rst) begin
            s_axi_awready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            spi_go        <= 1'b0;
            clear_ovf     <= 1'b0;
            ctrl          <= '0;
            spi_cmd       <= '0;
        end else begin
            s_axi_awready <= wr_take;
            s_axi_arready <= rd_take;
            spi_go        <= 1'b0;
            clear_ovf     <= 1'b0;

            if (s_axi_awready) begin
                s_axi_bvalid <= 1'b1;
                if (wr_hit) begin
                    case (s_axi_awaddr[7:0])
                        ads_pkg::REG_CTRL: begin
                            ctrl.op_mode  <= s_axi_wdata[ads_pkg::CTRL_MODE_BIT];
                            ctrl.ad_reset <= s_axi_wdata[ads_pkg::CTRL_RESET_BIT];
                            ctrl.ad_start <= s_axi_wdata[ads_pkg::CTRL_START_BIT];
                        end
                        ads_pkg::REG_STAT: begin
                            clear_ovf <= s_axi_wdata[ads_pkg::STAT_OVF_BIT];
                        end
                        ads_pkg::REG_SPICTRL: begin
                            spi_cmd.nbytes <= s_axi_wdata[1:0];
                        end
                        ads_pkg::REG_SPISEND: begin
                            spi_cmd.send <= s_axi_wdata;
                            spi_go       <= 1'b1;
                        end
                        default: ;  // VERSION and SPIRECV are read only
                    endcase
                end
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end

            if (s_axi_arready) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // ==============================
    // Read data
    // ==============================

    always_comb begin
        rd_word = 32'd0;
        case (s_axi_araddr[7:0])
            ads_pkg::REG_VERSION: rd_word = ads_pkg::VERSION_ID;
            ads_pkg::REG_CTRL: begin
                rd_word[ads_pkg::CTRL_MODE_BIT]  = ctrl.op_mode;
                rd_word[ads_pkg::CTRL_RESET_BIT] = ctrl.ad_reset;
                rd_word[ads_pkg::CTRL_START_BIT] = ctrl.ad_start;
            end
            ads_pkg::REG_STAT:    rd_word = 32'(stat);
            ads_pkg::REG_SPICTRL: rd_word = 32'(spi_cmd.nbytes);
            ads_pkg::REG_SPISEND: rd_word = spi_cmd.send;
            ads_pkg::REG_SPIRECV: rd_word = spi_recv;
            default:              rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (s_axi_awready) begin
            s_axi_bresp <= wr_hit ? ads_pkg::OKAY : ads_pkg::SLVERR;
        end
        if (s_axi_arready) begin
            s_axi_rresp <= rd_hit ? ads_pkg::OKAY : ads_pkg::SLVERR;
            s_axi_rdata <= rd_hit ? rd_word : 32'd0;
        end
    end

endmodule

`default_nettype wire

/* src/spi_byte_master.sv */
`default_nettype none

//  cs_n  ‾‾\____________________________________
//  sclk  ____/‾‾‾\___/‾‾‾\___ ... __/‾‾‾\_______
//  mosi  ----X b7    X b6    X ...  X b0  X-----
//  miso       sampled on each falling edge

module spi_byte_master (
    input  logic       aclk,
    input  logic       rst,
    input  logic       byte_start,
    input  logic [7:0] tx_byte,
    input  logic       miso,
    output logic       sclk,
    output logic       mosi,
    output logic [7:0] rx_byte,
    output logic       byte_done
);

    logic                           active;
    logic [ads_pkg::SCLK_DIV_W-1:0] div_cnt;
    logic [3:0]                     half_cnt;
    logic [7:0]                     tx_sh;
    logic                           tick;

    // End of a half period
    assign tick = active && (div_cnt == ads_pkg::SCLK_DIV_LAST);

    // Last tick closes the 16th half period, 64 cycles after byte_start
    assign byte_done = tick && (half_cnt == 4'd15);

    // ==============================
    // Clock and bit counters
    // ==============================

    always_ff @(posedge aclk) begin
        if (rst) begin
            active   <= 1'b0;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= 4'd0;
        end else if (byte_start) begin
            // First rising edge opens bit 7
            active   <= 1'b1;
            sclk     <= 1'b1;
            mosi     <= tx_byte[7];
            div_cnt  <= '0;
            half_cnt <= 4'd0;
        end else if (active) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                half_cnt <= half_cnt + 4'd1;
                if (!half_cnt[0]) begin
                    // Falling edge, next bit goes out half a period early
                    sclk <= 1'b0;
                    mosi <= tx_sh[6];
                end else if (half_cnt == 4'd15) begin
                    active <= 1'b0;
                end else begin
                    sclk <= 1'b1;
                end
            end
        end
    end

    // ==============================
    // Shift registers
    // ==============================

    always_ff @(posedge aclk) begin
        if (byte_start) begin
            tx_sh <= tx_byte;
        end else if (tick && !half_cnt[0]) begin
            tx_sh   <= {tx_sh[6:0], 1'b0};
            rx_byte <= {rx_byte[6:0], miso};
        end
    end

endmodule

`default_nettype wire
